//--- design/isa_pkg.sv
package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            func3_t;
    typedef logic [6:0]            func7_t;

    // major opcodes in inst[6:0]
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    // custom-0 carries the io instruction
    localparam opcode_t OPC_OUT    = 7'b0001011;

    // func3 values shared by register and immediate forms
    localparam func3_t F3_ADD_SUB = 3'b000;
    localparam func3_t F3_SLT     = 3'b010;
    localparam func3_t F3_XOR     = 3'b100;
    localparam func3_t F3_OR      = 3'b110;
    localparam func3_t F3_AND     = 3'b111;

    localparam func7_t F7_SUB = 7'b0100000;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    localparam int WINDOW_DEPTH = 4;
    localparam int WIN_PTR_W    = $clog2(WINDOW_DEPTH);

    // occupancy runs 0..WINDOW_DEPTH so it needs one bit more than a pointer
    typedef logic [WIN_PTR_W:0]   win_count_t;
    typedef logic [WIN_PTR_W-1:0] win_ptr_t;

    typedef enum logic [2:0] {
        EX_NONE    = 3'd0,
        EX_ALU     = 3'd1,
        EX_ALU_IMM = 3'd2,
        EX_LUI     = 3'd3,
        EX_OUT     = 3'd4
    } exec_type_t;

    // decode -> inst_window
    typedef struct packed {
        logic               valid;
        exec_type_t         exec_type;
        isa_pkg::reg_addr_t rs1;
        isa_pkg::reg_addr_t rs2;
        isa_pkg::reg_addr_t rd;
        isa_pkg::func3_t    func3;
        logic               sub;
        isa_pkg::word_t     imm;
        logic               spare;
    } dec_exec_info_t;

    // inst_window -> exec with operands already resolved
    typedef struct packed {
        logic               valid;
        exec_type_t         exec_type;
        isa_pkg::reg_addr_t rd;
        isa_pkg::func3_t    func3;
        logic               sub;
        isa_pkg::word_t     d_rs1;
        isa_pkg::word_t     d_rs2;
        isa_pkg::word_t     imm;
        logic [2:0]         spare;
    } exec_info_t;

    // exec -> reg_file and inst_window
    typedef struct packed {
        logic               order;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     d_rd;
    } write_d_r_t;

endpackage

//--- design/decode.sv
`timescale 1ns/100ps

module decode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     inst_valid,
    input  isa_pkg::inst_t           inst,
    output pipe_pkg::dec_exec_info_t dec_exec_info
);

    isa_pkg::opcode_t         opcode;
    isa_pkg::func3_t          func3;
    isa_pkg::func7_t          func7;
    logic                     f3_supported;
    logic                     f7_supported;
    pipe_pkg::dec_exec_info_t dec_next;

    assign opcode = inst[6:0];
    assign func3  = inst[14:12];
    assign func7  = inst[31:25];

    always_comb begin
        case (func3)
            isa_pkg::F3_ADD_SUB,
            isa_pkg::F3_SLT,
            isa_pkg::F3_XOR,
            isa_pkg::F3_OR,
            isa_pkg::F3_AND: f3_supported = 1'b1;
            default:         f3_supported = 1'b0;
        endcase
    end

    // only SUB uses a nonzero func7
    assign f7_supported = (func7 == '0)
        || (func7 == isa_pkg::F7_SUB && func3 == isa_pkg::F3_ADD_SUB);

    always_comb begin
        dec_next       = '0;
        dec_next.rd    = inst[11:7];
        dec_next.func3 = func3;
        case (opcode)
            isa_pkg::OPC_OP: begin
                if (f3_supported && f7_supported) begin
                    dec_next.exec_type = pipe_pkg::EX_ALU;
                    dec_next.rs1       = inst[19:15];
                    dec_next.rs2       = inst[24:20];
                    dec_next.sub       = (func7 == isa_pkg::F7_SUB);
                end
            end
            isa_pkg::OPC_OP_IMM: begin
                if (f3_supported) begin
                    dec_next.exec_type = pipe_pkg::EX_ALU_IMM;
                    dec_next.rs1       = inst[19:15];
                    // sign-extended I-type immediate
                    dec_next.imm       = {{20{inst[31]}}, inst[31:20]};
                end
            end
            isa_pkg::OPC_LUI: begin
                dec_next.exec_type = pipe_pkg::EX_LUI;
                dec_next.imm       = {inst[31:12], 12'b0};
            end
            isa_pkg::OPC_OUT: begin
                dec_next.exec_type = pipe_pkg::EX_OUT;
                dec_next.rs1       = inst[19:15];
            end
            default: begin
                dec_next.exec_type = pipe_pkg::EX_NONE;
            end
        endcase
        // unknown opcodes are dropped here
        dec_next.valid = inst_valid && (dec_next.exec_type != pipe_pkg::EX_NONE);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_exec_info <= '0;
        end else begin
            dec_exec_info <= dec_next;
        end
    end

endmodule

//--- design/inst_window.sv
`timescale 1ns/100ps

module inst_window (
    input  logic                     clk,
    input  logic                     reset,
    input  pipe_pkg::dec_exec_info_t dec_exec_info,
    input  logic                     out_busy,
    input  pipe_pkg::write_d_r_t     bypass,
    input  pipe_pkg::write_d_r_t     write_d_r,
    input  isa_pkg::word_t           rs1_data,
    input  isa_pkg::word_t           rs2_data,
    output isa_pkg::reg_addr_t       rs1_addr,
    output isa_pkg::reg_addr_t       rs2_addr,
    output pipe_pkg::exec_info_t     exec_info,
    output logic                     room
);

    pipe_pkg::dec_exec_info_t entries [pipe_pkg::WINDOW_DEPTH];
    pipe_pkg::win_ptr_t       head;
    pipe_pkg::win_ptr_t       tail;
    pipe_pkg::win_count_t     count;
    pipe_pkg::dec_exec_info_t head_entry;
    logic                     push;
    logic                     head_stall;
    logic                     issue;
    isa_pkg::word_t           d_rs1;
    isa_pkg::word_t           d_rs2;

    // newest value first from exec, then writeback, then the register file
    function automatic isa_pkg::word_t resolve(
        input isa_pkg::reg_addr_t   addr,
        input isa_pkg::word_t       rf_data,
        input pipe_pkg::write_d_r_t ex_fwd,
        input pipe_pkg::write_d_r_t wb_fwd
    );
        isa_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd.order && ex_fwd.rd == addr) begin
            value = ex_fwd.d_rd;
        end else if (wb_fwd.order && wb_fwd.rd == addr) begin
            value = wb_fwd.d_rd;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign push       = dec_exec_info.valid;
    assign head_entry = entries[head];

    // OUT waits at the head while the port is busy and holds back the rest
    assign head_stall = (head_entry.exec_type == pipe_pkg::EX_OUT) && out_busy;
    assign issue      = (count != '0) && !head_stall;

    assign rs1_addr = head_entry.rs1;
    assign rs2_addr = head_entry.rs2;
    assign d_rs1    = resolve(head_entry.rs1, rs1_data, bypass, write_d_r);
    assign d_rs2    = resolve(head_entry.rs2, rs2_data, bypass, write_d_r);

    // keeps one slot free for the instruction sitting in decode
    assign room = (count + pipe_pkg::win_count_t'(dec_exec_info.valid))
        <= pipe_pkg::win_count_t'(pipe_pkg::WINDOW_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= dec_exec_info;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (issue) begin
                head <= head + 1'b1;
            end
            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_info <= '0;
        end else begin
            exec_info.valid     <= issue;
            exec_info.exec_type <= head_entry.exec_type;
            exec_info.rd        <= head_entry.rd;
            exec_info.func3     <= head_entry.func3;
            exec_info.sub       <= head_entry.sub;
            exec_info.d_rs1     <= d_rs1;
            exec_info.d_rs2     <= d_rs2;
            exec_info.imm       <= head_entry.imm;
            exec_info.spare     <= '0;
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::write_d_r_t write_d_r,
    input  isa_pkg::reg_addr_t   rs1_addr,
    input  isa_pkg::reg_addr_t   rs2_addr,
    output isa_pkg::word_t       rs1_data,
    output isa_pkg::word_t       rs2_data
);

    // x0 has no storage
    isa_pkg::word_t regs [1:isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_d_r.order && write_d_r.rd != '0) begin
            regs[write_d_r.rd] <= write_d_r.d_rd;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- design/exec.sv
`timescale 1ns/100ps

module exec (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::exec_info_t exec_info,
    output pipe_pkg::write_d_r_t bypass,
    output pipe_pkg::write_d_r_t write_d_r,
    output logic                 out_valid,
    output isa_pkg::word_t       out_data
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_result;
    isa_pkg::word_t result;
    logic           writes_rd;
    logic           is_out;

    assign op_a = exec_info.d_rs1;
    assign op_b = (exec_info.exec_type == pipe_pkg::EX_ALU) ? exec_info.d_rs2
                                                            : exec_info.imm;

    always_comb begin
        case (exec_info.func3)
            isa_pkg::F3_ADD_SUB: begin
                // immediate forms never carry the sub bit
                if (exec_info.sub && exec_info.exec_type == pipe_pkg::EX_ALU) begin
                    alu_result = op_a - op_b;
                end else begin
                    alu_result = op_a + op_b;
                end
            end
            isa_pkg::F3_SLT: alu_result = isa_pkg::word_t'($signed(op_a) < $signed(op_b));
            isa_pkg::F3_XOR: alu_result = op_a ^ op_b;
            isa_pkg::F3_OR:  alu_result = op_a | op_b;
            isa_pkg::F3_AND: alu_result = op_a & op_b;
            default:         alu_result = '0;
        endcase
    end

    assign result = (exec_info.exec_type == pipe_pkg::EX_LUI) ? exec_info.imm : alu_result;

    assign writes_rd = exec_info.valid
        && (exec_info.exec_type == pipe_pkg::EX_ALU
            || exec_info.exec_type == pipe_pkg::EX_ALU_IMM
            || exec_info.exec_type == pipe_pkg::EX_LUI)
        && (exec_info.rd != '0);

    assign is_out = exec_info.valid && (exec_info.exec_type == pipe_pkg::EX_OUT);

    // same-cycle result for the window's forwarding
    assign bypass.order = writes_rd;
    assign bypass.rd    = exec_info.rd;
    assign bypass.d_rd  = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            write_d_r <= '0;
            out_valid <= 1'b0;
        end else begin
            write_d_r <= bypass;
            out_valid <= is_out;
        end
    end

    // port data only changes with an OUT
    always_ff @(posedge clk) begin
        if (is_out) begin
            out_data <= op_a;
        end
    end

endmodule

//--- design/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_valid,
    input  isa_pkg::inst_t inst,
    input  logic           out_busy,
    output logic           room,
    output logic           out_valid,
    output isa_pkg::word_t out_data
);

    pipe_pkg::dec_exec_info_t dec_exec_info;
    pipe_pkg::exec_info_t     exec_info;
    pipe_pkg::write_d_r_t     bypass;
    pipe_pkg::write_d_r_t     write_d_r;
    isa_pkg::reg_addr_t       rs1_addr;
    isa_pkg::reg_addr_t       rs2_addr;
    isa_pkg::word_t           rs1_data;
    isa_pkg::word_t           rs2_data;

    decode i_decode (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dec_exec_info (dec_exec_info)
    );

    inst_window i_inst_window (
        .clk           (clk),
        .reset         (reset),
        .dec_exec_info (dec_exec_info),
        .out_busy      (out_busy),
        .bypass        (bypass),
        .write_d_r     (write_d_r),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .exec_info     (exec_info),
        .room          (room)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .write_d_r (write_d_r),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    exec i_exec (
        .clk       (clk),
        .reset     (reset),
        .exec_info (exec_info),
        .bypass    (bypass),
        .write_d_r (write_d_r),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

//--- dv/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    typedef enum logic [1:0] {
        BUSY_OFF,
        BUSY_LFSR,
        BUSY_HOLD
    } busy_mode_t;

    typedef struct packed {
        logic [2:0]     test;
        busy_mode_t     mode;
        isa_pkg::inst_t inst;
        isa_pkg::word_t expected;
    } row_t;

    typedef struct packed {
        logic [2:0]     test;
        isa_pkg::word_t value;
    } out_exp_t;

    logic           clk;
    logic           reset;
    logic           inst_valid;
    isa_pkg::inst_t inst;
    logic           out_busy;
    logic           room;
    logic           out_valid;
    isa_pkg::word_t out_data;

    row_t        rows[$];
    out_exp_t    exp_q[$];
    int          errors[5];
    int          out_left[5];
    string       test_names[5];
    int          outs_seen;
    int          n_outs;
    int          stray_errors;
    logic [2:0]  row_test;
    busy_mode_t  row_mode;
    busy_mode_t  cur_mode;
    logic [31:0] lfsr_state;
    int          hold_cycles;
    logic        room_fell;
    bit          table_done;

    core_top i_core_top (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_busy   (out_busy),
        .room       (room),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    always #4 clk = ~clk;

    function automatic isa_pkg::inst_t r_type(input isa_pkg::func3_t f3, input logic sub,
        input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs1,
        input isa_pkg::reg_addr_t rs2);
        isa_pkg::func7_t f7;
        f7 = sub ? isa_pkg::F7_SUB : 7'b0;
        return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    endfunction

    function automatic isa_pkg::inst_t i_type(input isa_pkg::func3_t f3,
        input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic isa_pkg::inst_t lui_type(input isa_pkg::reg_addr_t rd,
        input logic [19:0] imm);
        return {imm, rd, isa_pkg::OPC_LUI};
    endfunction

    function automatic isa_pkg::inst_t out_inst(input isa_pkg::reg_addr_t rs1);
        return {12'b0, rs1, 3'b000, 5'b0, isa_pkg::OPC_OUT};
    endfunction

    // fibonacci form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic add_row(input isa_pkg::inst_t word, input isa_pkg::word_t expected);
        row_t     r;
        out_exp_t e;
        r.test     = row_test;
        r.mode     = row_mode;
        r.inst     = word;
        r.expected = expected;
        rows.push_back(r);
        if (word[6:0] == isa_pkg::OPC_OUT) begin
            e.test  = row_test;
            e.value = expected;
            exp_q.push_back(e);
            out_left[row_test]++;
            n_outs++;
        end
    endtask

    task automatic build_table();
        row_test = 3'd1;
        row_mode = BUSY_OFF;
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'd100), 32'h0);
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd2, 5'd0, 12'hff9), 32'h0);
        add_row(out_inst(5'd2), 32'hffff_fff9);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b0, 5'd3, 5'd1, 5'd2), 32'h0);
        add_row(out_inst(5'd3), 32'h0000_005d);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b1, 5'd4, 5'd2, 5'd1), 32'h0);
        add_row(out_inst(5'd4), 32'hffff_ff95);
        add_row(r_type(isa_pkg::F3_AND, 1'b0, 5'd5, 5'd1, 5'd2), 32'h0);
        add_row(out_inst(5'd5), 32'h0000_0060);
        add_row(r_type(isa_pkg::F3_OR, 1'b0, 5'd6, 5'd1, 5'd2), 32'h0);
        add_row(out_inst(5'd6), 32'hffff_fffd);
        add_row(r_type(isa_pkg::F3_XOR, 1'b0, 5'd7, 5'd1, 5'd2), 32'h0);
        add_row(out_inst(5'd7), 32'hffff_ff9d);
        // -107 < -7
        add_row(r_type(isa_pkg::F3_SLT, 1'b0, 5'd8, 5'd4, 5'd2), 32'h0);
        add_row(out_inst(5'd8), 32'h0000_0001);
        add_row(i_type(isa_pkg::F3_AND, 5'd10, 5'd2, 12'h0f0), 32'h0);
        add_row(out_inst(5'd10), 32'h0000_00f0);
        add_row(i_type(isa_pkg::F3_OR, 5'd11, 5'd1, 12'h703), 32'h0);
        add_row(out_inst(5'd11), 32'h0000_0767);
        add_row(i_type(isa_pkg::F3_XOR, 5'd12, 5'd1, 12'hfff), 32'h0);
        add_row(out_inst(5'd12), 32'hffff_ff9b);
        add_row(i_type(isa_pkg::F3_SLT, 5'd13, 5'd2, 12'hffa), 32'h0);
        add_row(out_inst(5'd13), 32'h0000_0001);
        add_row(lui_type(5'd14, 20'habcde), 32'h0);
        add_row(out_inst(5'd14), 32'habcd_e000);
        // each result feeds the next one or two instructions
        row_test = 3'd2;
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd20, 5'd0, 12'd5), 32'h0);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b0, 5'd21, 5'd20, 5'd20), 32'h0);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b0, 5'd22, 5'd21, 5'd20), 32'h0);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b1, 5'd23, 5'd22, 5'd21), 32'h0);
        add_row(i_type(isa_pkg::F3_XOR, 5'd24, 5'd23, 12'h00f), 32'h0);
        add_row(out_inst(5'd24), 32'h0000_000a);
        add_row(out_inst(5'd22), 32'h0000_000f);
        add_row(out_inst(5'd23), 32'h0000_0005);
        row_test = 3'd3;
        row_mode = BUSY_LFSR;
        add_row(out_inst(5'd3), 32'h0000_005d);
        add_row(out_inst(5'd4), 32'hffff_ff95);
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd25, 5'd0, 12'h123), 32'h0);
        add_row(out_inst(5'd25), 32'h0000_0123);
        row_mode = BUSY_HOLD;
        add_row(out_inst(5'd1), 32'h0000_0064);
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd26, 5'd25, 12'd1), 32'h0);
        add_row(out_inst(5'd26), 32'h0000_0124);
        add_row(r_type(isa_pkg::F3_XOR, 1'b0, 5'd27, 5'd26, 5'd25), 32'h0);
        add_row(out_inst(5'd27), 32'h0000_0007);
        row_mode = BUSY_LFSR;
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b0, 5'd28, 5'd27, 5'd26), 32'h0);
        add_row(out_inst(5'd28), 32'h0000_012b);
        add_row(out_inst(5'd14), 32'habcd_e000);
        row_test = 3'd4;
        row_mode = BUSY_OFF;
        add_row(i_type(isa_pkg::F3_ADD_SUB, 5'd0, 5'd0, 12'd55), 32'h0);
        add_row(out_inst(5'd0), 32'h0);
        add_row(r_type(isa_pkg::F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 5'd1), 32'h0);
        add_row(out_inst(5'd0), 32'h0);
        // load, jal and sll all aim at x1 and must be dropped
        add_row({12'h7ff, 5'd0, 3'b010, 5'd1, 7'b0000011}, 32'h0);
        add_row({20'h00010, 5'd1, 7'b1101111}, 32'h0);
        add_row({7'b0, 5'd1, 5'd1, 3'b001, 5'd1, isa_pkg::OPC_OP}, 32'h0);
        add_row(out_inst(5'd1), 32'h0000_0064);
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t actual,
        input isa_pkg::word_t expected, input int test);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors[test]++;
        end
    endtask

    task automatic finish_test(input int test);
        $display("test %0d (%s): %0d errors", test, test_names[test], errors[test]);
    endtask

    // one call per falling edge
    task automatic set_busy();
        case (cur_mode)
            BUSY_LFSR: begin
                lfsr_state = lfsr_step(lfsr_state);
                out_busy   = lfsr_state[0];
            end
            BUSY_HOLD: begin
                // held about twelve cycles to fill the window
                out_busy = (hold_cycles < 12);
                hold_cycles++;
                if (out_busy && !room) begin
                    room_fell = 1'b1;
                end
            end
            default: out_busy = 1'b0;
        endcase
    endtask

    // outputs are compared in order on the falling edge
    always @(negedge clk) begin
        out_exp_t expected_out;
        if (!reset && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("out_valid at %0t with no OUT pending, out_data %h", $time, out_data);
                stray_errors++;
            end
            if (exp_q.size() != 0) begin
                expected_out = exp_q.pop_front();
                check_word("out_data", out_data, expected_out.value, int'(expected_out.test));
                outs_seen++;
                out_left[expected_out.test]--;
                if (out_left[expected_out.test] == 0) begin
                    finish_test(int'(expected_out.test));
                end
            end
        end
    end

    initial begin
        wait (table_done);
        repeat (rows.size() * 40 + 200) @(posedge clk);
        $display("timeout: %0d of %0d OUT values never arrived", n_outs - outs_seen, n_outs);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic accepted;
        int   pass_count;
        int   fail_count;
        clk          = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        out_busy     = 1'b0;
        cur_mode     = BUSY_OFF;
        lfsr_state   = 32'h64c9;
        hold_cycles  = 0;
        room_fell    = 1'b0;
        outs_seen    = 0;
        n_outs       = 0;
        stray_errors = 0;
        test_names   = '{"reset_state", "alu_ops", "dependencies", "back_pressure", "x0_unknown"};
        for (int t = 0; t < 5; t++) begin
            errors[t]   = 0;
            out_left[t] = 0;
        end
        build_table();
        table_done = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_word("room", 32'(room), 32'h1, 0);
            check_word("out_valid", 32'(out_valid), 32'h0, 0);
        end
        finish_test(0);

        foreach (rows[i]) begin
            if (cur_mode == BUSY_HOLD && rows[i].mode != BUSY_HOLD) begin
                assert (room_fell) else begin
                    $display("room never fell while out_busy was held high");
                    errors[rows[i-1].test]++;
                end
            end
            cur_mode = rows[i].mode;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                set_busy();
                inst_valid = 1'b0;
                if (room) begin
                    inst       = rows[i].inst;
                    inst_valid = 1'b1;
                    accepted   = 1'b1;
                end
            end
        end
        @(negedge clk);
        cur_mode = BUSY_OFF;
        set_busy();
        inst_valid = 1'b0;
        inst       = '0;

        wait (outs_seen == n_outs);
        // a few more cycles to catch extra outputs
        repeat (10) @(negedge clk);
        pass_count = 0;
        fail_count = 0;
        for (int t = 0; t < 5; t++) begin
            if (errors[t] == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
        end
        $display("%0d tests passed, %0d tests failed, %0d stray outputs",
            pass_count, fail_count, stray_errors);
        if (fail_count == 0 && stray_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode.sv
design/inst_window.sv
design/reg_file.sv
design/exec.sv
design/core_top.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module core_tb -o core_tb_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/core_tb_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
